// ==== Makefile ====
# Verilator flow for the Wishbone memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= wb_sys_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(wildcard *.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test: $(SIM)
	./$(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== mmio_catcher.sv ====
`default_nettype none

module mmio_catcher (
  input  wire                       HCLK,
  input  wire                       rst_n_i,
  input  wire                       stb_i,
  input  wire  [wb_pkg::PLEN-1:0]   adr_i,
  input  wire  [wb_pkg::XLEN-1:0]   dat_i,
  input  wire  [wb_pkg::SEL_W-1:0]  sel_i,
  input  wire                       we_i,
  output logic                      ack_o,
  output logic [wb_pkg::XLEN-1:0]   rdat_o,
  // UART byte stream, no back-pressure
  output logic                      uart_valid_o,
  output logic [7:0]                uart_data_o,
  // Test end
  output logic                      done_o,
  output logic [wb_pkg::XLEN-2:0]   exit_code_o
);

  wb_pkg::resp_e           state;
  logic                    take;
  logic                    hit_tohost;
  logic                    hit_uart;
  logic [wb_pkg::XLEN-1:0] tohost_q;
  logic [wb_pkg::XLEN-1:0] tohost_nxt;

  assign take = stb_i && (state == wb_pkg::RESP_IDLE);

  // Address decode, tohost block and UART word
  assign hit_tohost = (adr_i & ~(pma_pkg::TOHOST_SIZE - 1)) == pma_pkg::TOHOST_ADR;
  assign hit_uart   = adr_i[wb_pkg::PLEN-1:2] == pma_pkg::UART_TX_ADR[wb_pkg::PLEN-1:2];

  assign tohost_nxt = wb_pkg::sel_merge(tohost_q, dat_i, sel_i);

  //////////////////////////////
  // Control registers
  //////////////////////////////

  always_ff @(posedge HCLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state        <= wb_pkg::RESP_IDLE;
      tohost_q     <= '0;
      done_o       <= 1'b0;
      exit_code_o  <= '0;
      uart_valid_o <= 1'b0;
    end else begin
      if (take) begin
        state <= wb_pkg::RESP_ACK;
      end else begin
        state <= wb_pkg::RESP_IDLE;
      end
      // One pulse per UART write, lined up with ack
      uart_valid_o <= take && we_i && hit_uart;
      if (take && we_i && hit_tohost) begin
        tohost_q <= tohost_nxt;
        // Bit 0 marks test end, sticky
        if (tohost_nxt[0]) begin
          done_o      <= 1'b1;
          exit_code_o <= tohost_nxt[wb_pkg::XLEN-1:1];
        end
      end
    end
  end

  assign ack_o = (state == wb_pkg::RESP_ACK);

  // Payload
  always_ff @(posedge HCLK) begin
    if (take && we_i && hit_uart) begin
      uart_data_o <= dat_i[7:0];
    end
    if (take) begin
      rdat_o <= (hit_tohost && !we_i) ? tohost_q : '0;
    end
  end

endmodule

`default_nettype wire

// ==== pma_pkg.sv ====
`default_nettype none

package pma_pkg;

  // Memory type of a region
  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_MAIN,
    MEM_IO
  } mem_type_e;

  // Address match mode of a region
  typedef enum logic [1:0] {
    PMA_TOR,
    PMA_NA4,
    PMA_NAPOT
  } match_e;

  // Permission bits
  localparam int             PERM_BITS  = 3;
  localparam logic [PERM_BITS-1:0] PERM_READ  = 3'b001;
  localparam logic [PERM_BITS-1:0] PERM_WRITE = 3'b010;
  localparam logic [PERM_BITS-1:0] PERM_EXEC  = 3'b100;

  //////////////////////////////
  // Region map
  //////////////////////////////

  localparam int PMA_CNT = 3;

  // RAM, 4 KiB main memory
  localparam logic [wb_pkg::PLEN-1:0] RAM_BASE = 32'h8000_0000;
  localparam logic [wb_pkg::PLEN-1:0] RAM_TOP  = 32'h8000_0FFF;

  // Tohost, 16 byte naturally aligned block
  localparam logic [wb_pkg::PLEN-1:0] TOHOST_ADR  = 32'h8000_1000;
  localparam logic [wb_pkg::PLEN-1:0] TOHOST_SIZE = 32'h0000_0010;
  localparam logic [wb_pkg::PLEN-1:0] TOHOST_LAST = TOHOST_ADR + TOHOST_SIZE - 1;

  // UART transmit, single word
  localparam logic [wb_pkg::PLEN-1:0] UART_TX_ADR = 32'h8000_1080;

  // Per-region tables, lower index has priority
  localparam logic [wb_pkg::PLEN-1:0] PMA_BASE [PMA_CNT] = '{RAM_BASE, TOHOST_ADR, UART_TX_ADR};
  localparam logic [wb_pkg::PLEN-1:0] PMA_LAST [PMA_CNT] = '{RAM_TOP, TOHOST_LAST,
                                                            UART_TX_ADR + 3};
  localparam match_e    PMA_MODE [PMA_CNT] = '{PMA_TOR, PMA_NAPOT, PMA_NA4};
  localparam mem_type_e PMA_TYPE [PMA_CNT] = '{MEM_MAIN, MEM_IO, MEM_IO};
  localparam logic [PERM_BITS-1:0] PMA_PERM [PMA_CNT] = '{
    PERM_READ | PERM_WRITE | PERM_EXEC,
    PERM_READ | PERM_WRITE,
    PERM_WRITE
  };

endpackage

`default_nettype wire

// ==== tb.f ====
wb_pkg.sv
pma_pkg.sv
wb_port_guard.sv
wb_mem_model.sv
mmio_catcher.sv
wb_sys_top.sv
wb_sys_chk.sv
wb_sys_tb.sv

// ==== wb_mem_model.sv ====
`default_nettype none

module wb_mem_model (
  input  wire                       HCLK,
  input  wire                       rst_n_i,
  // Port a, instruction side
  input  wire                       a_stb_i,
  input  wire  [wb_pkg::PLEN-1:0]   a_adr_i,
  input  wire  [wb_pkg::XLEN-1:0]   a_dat_i,
  input  wire  [wb_pkg::SEL_W-1:0]  a_sel_i,
  input  wire                       a_we_i,
  // Port b, data side
  input  wire                       b_stb_i,
  input  wire  [wb_pkg::PLEN-1:0]   b_adr_i,
  input  wire  [wb_pkg::XLEN-1:0]   b_dat_i,
  input  wire  [wb_pkg::SEL_W-1:0]  b_sel_i,
  input  wire                       b_we_i,
  // Responses
  output logic                      a_ack_o,
  output logic [wb_pkg::XLEN-1:0]   a_rdat_o,
  output logic                      b_ack_o,
  output logic [wb_pkg::XLEN-1:0]   b_rdat_o
);

  localparam int AW = wb_pkg::MEM_AW;

  // Word array, contents survive reset
  logic [wb_pkg::XLEN-1:0] mem [wb_pkg::MEM_WORDS];

  logic [wb_pkg::PLEN-1:0] a_off;
  logic [wb_pkg::PLEN-1:0] b_off;
  logic [AW-1:0]           a_idx;
  logic [AW-1:0]           b_idx;
  logic                    a_take;
  logic                    b_take;
  wb_pkg::resp_e           a_state;
  wb_pkg::resp_e           b_state;

  // Word index relative to RAM base
  assign a_off = a_adr_i - pma_pkg::RAM_BASE;
  assign b_off = b_adr_i - pma_pkg::RAM_BASE;
  assign a_idx = a_off[AW+1:2];
  assign b_idx = b_off[AW+1:2];

  // Sample only when idle
  assign a_take = a_stb_i && (a_state == wb_pkg::RESP_IDLE);
  assign b_take = b_stb_i && (b_state == wb_pkg::RESP_IDLE);

  //////////////////////////////
  // Response state
  //////////////////////////////

  always_ff @(posedge HCLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_state <= wb_pkg::RESP_IDLE;
    end else if (a_take) begin
      a_state <= wb_pkg::RESP_ACK;
    end else begin
      a_state <= wb_pkg::RESP_IDLE;
    end
  end

  always_ff @(posedge HCLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_state <= wb_pkg::RESP_IDLE;
    end else if (b_take) begin
      b_state <= wb_pkg::RESP_ACK;
    end else begin
      b_state <= wb_pkg::RESP_IDLE;
    end
  end

  assign a_ack_o = (a_state == wb_pkg::RESP_ACK);
  assign b_ack_o = (b_state == wb_pkg::RESP_ACK);

  //////////////////////////////
  // Array access
  //////////////////////////////

  // Port b written last so it wins a same-word collision
  always_ff @(posedge HCLK) begin
    if (a_take && a_we_i) begin
      mem[a_idx] <= wb_pkg::sel_merge(mem[a_idx], a_dat_i, a_sel_i);
    end
    if (b_take && b_we_i) begin
      mem[b_idx] <= wb_pkg::sel_merge(mem[b_idx], b_dat_i, b_sel_i);
    end
  end

  // Read data registered at sampling, old contents
  always_ff @(posedge HCLK) begin
    if (a_take) begin
      a_rdat_o <= mem[a_idx];
    end
    if (b_take) begin
      b_rdat_o <= mem[b_idx];
    end
  end

endmodule

`default_nettype wire

// ==== wb_pkg.sv ====
`default_nettype none

package wb_pkg;

  //////////////////////////////
  // Bus geometry
  //////////////////////////////

  // Data and address widths
  localparam int XLEN  = 32;
  localparam int PLEN  = 32;
  // One select bit per byte lane
  localparam int SEL_W = XLEN / 8;

  // RAM depth in words, 4 KiB
  localparam int MEM_WORDS = 1024;
  localparam int MEM_AW    = $clog2(MEM_WORDS);

  // Slave response state, shared by every responder
  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_ACK,
    RESP_ERR
  } resp_e;

  // Byte-lane merge, only lanes with sel set take new data
  function automatic logic [XLEN-1:0] sel_merge(input logic [XLEN-1:0]  old_w,
                                                input logic [XLEN-1:0]  new_w,
                                                input logic [SEL_W-1:0] sel);
    logic [XLEN-1:0] res;
    res = old_w;
    for (int i = 0; i < SEL_W; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== wb_port_guard.sv ====
`default_nettype none

module wb_port_guard #(
  parameter bit IS_FETCH = 1'b0
) (
  input  wire                        HCLK,
  input  wire                        rst_n_i,
  // Wishbone slave side, from the core
  input  wire  [wb_pkg::PLEN-1:0]    adr_i,
  input  wire  [wb_pkg::XLEN-1:0]    dat_i,
  input  wire  [wb_pkg::SEL_W-1:0]   sel_i,
  input  wire                        we_i,
  input  wire                        cyc_i,
  input  wire                        stb_i,
  output logic                       ack_o,
  output logic                       err_o,
  output logic [wb_pkg::XLEN-1:0]    rdat_o,
  // Downstream strobes
  output logic                       main_stb_o,
  output logic                       io_stb_o,
  output logic [wb_pkg::PLEN-1:0]    fwd_adr_o,
  output logic [wb_pkg::XLEN-1:0]    fwd_dat_o,
  output logic [wb_pkg::SEL_W-1:0]   fwd_sel_o,
  output logic                       fwd_we_o,
  // Target responses
  input  wire                        main_ack_i,
  input  wire  [wb_pkg::XLEN-1:0]    main_rdat_i,
  input  wire                        io_ack_i,
  input  wire  [wb_pkg::XLEN-1:0]    io_rdat_i
);

  logic [pma_pkg::PMA_CNT-1:0]    hit;
  pma_pkg::mem_type_e             mtype;
  logic [pma_pkg::PERM_BITS-1:0]  perm;
  logic [pma_pkg::PERM_BITS-1:0]  need;
  logic                           allowed;
  logic                           req;
  logic                           fault;
  wb_pkg::resp_e                  err_state;

  //////////////////////////////
  // Region lookup
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < pma_pkg::PMA_CNT; i++) begin
      case (pma_pkg::PMA_MODE[i])
        // Inclusive range
        pma_pkg::PMA_TOR: begin
          hit[i] = (adr_i >= pma_pkg::PMA_BASE[i]) && (adr_i <= pma_pkg::PMA_LAST[i]);
        end
        // Single aligned word
        pma_pkg::PMA_NA4: begin
          hit[i] = adr_i[wb_pkg::PLEN-1:2] == pma_pkg::PMA_BASE[i][wb_pkg::PLEN-1:2];
        end
        // Size mask is last minus base
        pma_pkg::PMA_NAPOT: begin
          hit[i] = (adr_i & ~(pma_pkg::PMA_LAST[i] - pma_pkg::PMA_BASE[i])) ==
                   pma_pkg::PMA_BASE[i];
        end
        default: begin
          hit[i] = 1'b0;
        end
      endcase
    end
  end

  // Lowest matching index wins
  always_comb begin
    mtype = pma_pkg::MEM_NONE;
    perm  = '0;
    for (int i = pma_pkg::PMA_CNT - 1; i >= 0; i--) begin
      if (hit[i]) begin
        mtype = pma_pkg::PMA_TYPE[i];
        perm  = pma_pkg::PMA_PERM[i];
      end
    end
  end

  //////////////////////////////
  // Permission check
  //////////////////////////////

  // Fetch needs X, else W or R by direction
  assign need    = IS_FETCH ? pma_pkg::PERM_EXEC :
                   (we_i ? pma_pkg::PERM_WRITE : pma_pkg::PERM_READ);
  // Fetch port never writes
  assign allowed = (mtype != pma_pkg::MEM_NONE) && ((perm & need) != '0) &&
                   !(IS_FETCH && we_i);

  assign req   = cyc_i && stb_i;
  assign fault = req && !allowed;

  // Gated strobes, none on a fault
  assign main_stb_o = req && allowed && (mtype == pma_pkg::MEM_MAIN);
  assign io_stb_o   = req && allowed && (mtype == pma_pkg::MEM_IO);

  assign fwd_adr_o = adr_i;
  assign fwd_dat_o = dat_i;
  assign fwd_sel_o = sel_i;
  assign fwd_we_o  = we_i;

  // Fault responder, err one cycle after sampling
  always_ff @(posedge HCLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_state <= wb_pkg::RESP_IDLE;
    end else if ((err_state == wb_pkg::RESP_IDLE) && fault) begin
      err_state <= wb_pkg::RESP_ERR;
    end else begin
      err_state <= wb_pkg::RESP_IDLE;
    end
  end

  assign err_o = (err_state == wb_pkg::RESP_ERR);

  // Merge target responses
  assign ack_o  = main_ack_i || io_ack_i;
  assign rdat_o = ({wb_pkg::XLEN{main_ack_i}} & main_rdat_i) |
                  ({wb_pkg::XLEN{io_ack_i}} & io_rdat_i);

endmodule

`default_nettype wire

// ==== wb_sys_chk.sv ====
`default_nettype none

module wb_sys_chk (
  input wire HCLK,
  input wire rst_n_i,
  input wire ins_cyc_i,
  input wire ins_stb_i,
  input wire ins_ack_o,
  input wire ins_err_o,
  input wire dat_cyc_i,
  input wire dat_stb_i,
  input wire dat_ack_o,
  input wire dat_err_o,
  input wire uart_valid_o,
  input wire done_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Count of assertion failures
  int err_cnt = 0;

  //////////////////////////////
  // Instruction port
  //////////////////////////////

  ins_excl: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    !(ins_ack_o && ins_err_o))
    else begin
      err_cnt++;
      $error("ins port ack and err high together");
    end
  // Single-cycle response
  ins_width: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (ins_ack_o || ins_err_o) |=> !(ins_ack_o || ins_err_o))
    else begin
      err_cnt++;
      $error("ins port response wider than one cycle");
    end
  ins_cause: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (ins_ack_o || ins_err_o) |-> $past(ins_cyc_i && ins_stb_i))
    else begin
      err_cnt++;
      $error("ins port response without a request");
    end

  //////////////////////////////
  // Data port
  //////////////////////////////

  dat_excl: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    !(dat_ack_o && dat_err_o))
    else begin
      err_cnt++;
      $error("dat port ack and err high together");
    end
  dat_width: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (dat_ack_o || dat_err_o) |=> !(dat_ack_o || dat_err_o))
    else begin
      err_cnt++;
      $error("dat port response wider than one cycle");
    end
  dat_cause: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (dat_ack_o || dat_err_o) |-> $past(dat_cyc_i && dat_stb_i))
    else begin
      err_cnt++;
      $error("dat port response without a request");
    end

  // Quiet while held in reset
  reset_quiet: assert property (@(posedge HCLK) !rst_n_i |->
    !(ins_ack_o || ins_err_o || dat_ack_o || dat_err_o || uart_valid_o || done_o))
    else begin
      err_cnt++;
      $error("response or status output high during reset");
    end

endmodule

bind wb_sys_top wb_sys_chk protocol_chk (
  .HCLK         (HCLK),
  .rst_n_i      (rst_n_i),
  .ins_cyc_i    (ins_cyc_i),
  .ins_stb_i    (ins_stb_i),
  .ins_ack_o    (ins_ack_o),
  .ins_err_o    (ins_err_o),
  .dat_cyc_i    (dat_cyc_i),
  .dat_stb_i    (dat_stb_i),
  .dat_ack_o    (dat_ack_o),
  .dat_err_o    (dat_err_o),
  .uart_valid_o (uart_valid_o),
  .done_o       (done_o)
);

`default_nettype wire

// ==== wb_sys_tb.sv ====
`default_nettype none

module wb_sys_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD     = 8;
  localparam int          RESET_CYCLES   = 5;
  localparam int          ENTRY_LIMIT    = 8;
  localparam int          RESP_LATENCY   = 1;
  localparam int          TIMEOUT_MARGIN = 100;
  localparam logic [31:0] SEED           = 32'd59369;

  // Which port an entry drives
  localparam int PORT_INS  = 0;
  localparam int PORT_DAT  = 1;
  localparam int PORT_BOTH = 2;

  typedef struct {
    string                     name;
    int                        port;
    logic                      we;
    logic [wb_pkg::PLEN-1:0]   adr;
    logic [wb_pkg::SEL_W-1:0]  sel;
    logic [wb_pkg::XLEN-1:0]   wdata;
    logic                      exp_ack;
    logic [wb_pkg::XLEN-1:0]   exp_rdat;
    logic                      exp_uart;
    logic [7:0]                exp_byte;
    logic                      exp_done;
    logic [wb_pkg::XLEN-2:0]   exp_exit;
  } entry_t;

  logic                     HCLK;
  logic                     rst_n_i;
  logic [wb_pkg::PLEN-1:0]  ins_adr_i;
  logic [wb_pkg::XLEN-1:0]  ins_dat_i;
  logic [wb_pkg::SEL_W-1:0] ins_sel_i;
  logic                     ins_we_i;
  logic                     ins_cyc_i;
  logic                     ins_stb_i;
  logic [wb_pkg::PLEN-1:0]  dat_adr_i;
  logic [wb_pkg::XLEN-1:0]  dat_dat_i;
  logic [wb_pkg::SEL_W-1:0] dat_sel_i;
  logic                     dat_we_i;
  logic                     dat_cyc_i;
  logic                     dat_stb_i;
  logic [wb_pkg::XLEN-1:0]  ins_rdat_o;
  logic                     ins_ack_o;
  logic                     ins_err_o;
  logic [wb_pkg::XLEN-1:0]  dat_rdat_o;
  logic                     dat_ack_o;
  logic                     dat_err_o;
  logic                     uart_valid_o;
  logic [7:0]               uart_data_o;
  logic                     done_o;
  logic [wb_pkg::XLEN-2:0]  exit_code_o;

  // Stimulus table and reference state
  entry_t                  tbl[$];
  logic [wb_pkg::XLEN-1:0] ref_mem [wb_pkg::MEM_WORDS];
  logic [wb_pkg::XLEN-1:0] tohost_ref;
  logic                    done_ref;
  logic [wb_pkg::XLEN-2:0] exit_ref;
  logic [31:0]             lcg_state;
  logic                    table_ready;

  wb_sys_top wb_sys_top_inst (.*);

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Lane mask built from sel, then blend
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic in_ram(input logic [31:0] adr);
    return (adr >= pma_pkg::RAM_BASE) && (adr <= pma_pkg::RAM_TOP);
  endfunction

  function automatic logic in_tohost(input logic [31:0] adr);
    return (adr >= pma_pkg::TOHOST_ADR) && (adr <= pma_pkg::TOHOST_ADR + 32'd15);
  endfunction

  function automatic logic in_uart(input logic [31:0] adr);
    return adr[31:2] == pma_pkg::UART_TX_ADR[31:2];
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      fail_run($sformatf("error %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  // Predict the response and side effects and update the models
  task automatic add_entry(input string name, input int port, input logic we,
                           input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] wdata);
    entry_t e;
    logic   ok;
    int     idx;
    // Fetch only reads RAM while data may use any permitted region
    if (port == PORT_DAT) begin
      ok = in_ram(adr) || in_tohost(adr) || (in_uart(adr) && we);
    end else begin
      ok = in_ram(adr) && !we;
    end
    e.name     = name;
    e.port     = port;
    e.we       = we;
    e.adr      = adr;
    e.sel      = sel;
    e.wdata    = wdata;
    e.exp_ack  = ok;
    e.exp_rdat = '0;
    e.exp_byte = wdata[7:0];
    e.exp_uart = ok && in_uart(adr) && we;
    if (ok && in_ram(adr)) begin
      idx = int'((adr - pma_pkg::RAM_BASE) >> 2);
      if (we) begin
        ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, sel);
      end else begin
        e.exp_rdat = ref_mem[idx];
      end
    end
    if (ok && in_tohost(adr)) begin
      if (we) begin
        tohost_ref = merge_bytes(tohost_ref, wdata, sel);
        // Bit 0 ends the test
        if (tohost_ref[0]) begin
          done_ref = 1'b1;
          exit_ref = tohost_ref[31:1];
        end
      end else begin
        e.exp_rdat = tohost_ref;
      end
    end
    e.exp_done = done_ref;
    e.exp_exit = exit_ref;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] b;
    b = pma_pkg::RAM_BASE;
    // Full words first so partial writes merge into known data
    for (int i = 0; i < 5; i++) begin
      add_entry($sformatf("fill_%0d", i), PORT_DAT, 1'b1, b + 32'(4 * i), 4'hF, lcg_next());
    end
    add_entry("part_w1", PORT_DAT, 1'b1, b + 32'h04, 4'b0001, lcg_next());
    add_entry("part_w2", PORT_DAT, 1'b1, b + 32'h08, 4'b0110, lcg_next());
    add_entry("part_w3", PORT_DAT, 1'b1, b + 32'h0C, 4'b1000, lcg_next());
    add_entry("part_w4", PORT_DAT, 1'b1, b + 32'h10, 4'b1010, lcg_next());
    for (int i = 0; i < 5; i++) begin
      add_entry($sformatf("read_%0d", i), PORT_DAT, 1'b0, b + 32'(4 * i), 4'hF, '0);
    end
    add_entry("fetch_0", PORT_INS, 1'b0, b + 32'h00, 4'hF, '0);
    add_entry("fetch_2", PORT_INS, 1'b0, b + 32'h08, 4'hF, '0);
    add_entry("dual_1", PORT_BOTH, 1'b0, b + 32'h04, 4'hF, '0);
    add_entry("dual_4", PORT_BOTH, 1'b0, b + 32'h10, 4'hF, '0);
    // Faults
    add_entry("dat_unmapped", PORT_DAT, 1'b1, 32'h0000_0100, 4'hF, lcg_next());
    add_entry("ins_unmapped", PORT_INS, 1'b0, 32'h9000_0000, 4'hF, '0);
    add_entry("ins_tohost", PORT_INS, 1'b0, pma_pkg::TOHOST_ADR, 4'hF, '0);
    add_entry("uart_read", PORT_DAT, 1'b0, pma_pkg::UART_TX_ADR, 4'hF, '0);
    add_entry("ins_write_2", PORT_INS, 1'b1, b + 32'h08, 4'hF, lcg_next());
    add_entry("keep_2", PORT_DAT, 1'b0, b + 32'h08, 4'hF, '0);
    add_entry("ins_write_3", PORT_INS, 1'b1, b + 32'h0C, 4'b0011, lcg_next());
    add_entry("keep_3", PORT_INS, 1'b0, b + 32'h0C, 4'hF, '0);
    // MMIO
    add_entry("uart_rand", PORT_DAT, 1'b1, pma_pkg::UART_TX_ADR, 4'hF, lcg_next());
    add_entry("uart_char", PORT_DAT, 1'b1, pma_pkg::UART_TX_ADR, 4'hF, 32'h0000_0041);
    add_entry("tohost_run", PORT_DAT, 1'b1, pma_pkg::TOHOST_ADR, 4'hF, lcg_next() & ~32'h1);
    add_entry("tohost_rd1", PORT_DAT, 1'b0, pma_pkg::TOHOST_ADR, 4'hF, '0);
    add_entry("tohost_end", PORT_DAT, 1'b1, pma_pkg::TOHOST_ADR, 4'hF, lcg_next() | 32'h1);
    add_entry("tohost_rd2", PORT_DAT, 1'b0, pma_pkg::TOHOST_ADR, 4'hF, '0);
  endtask

  //////////////////////////////
  // Entry driver
  //////////////////////////////

  task automatic apply_entry(input entry_t e);
    int   cycles;
    logic ins_busy;
    logic dat_busy;
    cycles   = 0;
    ins_busy = (e.port != PORT_DAT);
    dat_busy = (e.port != PORT_INS);
    @(negedge HCLK);
    if (ins_busy) begin
      ins_adr_i = e.adr;
      ins_dat_i = e.wdata;
      ins_sel_i = e.sel;
      ins_we_i  = e.we;
      ins_cyc_i = 1'b1;
      ins_stb_i = 1'b1;
    end
    if (dat_busy) begin
      dat_adr_i = e.adr;
      dat_dat_i = e.wdata;
      dat_sel_i = e.sel;
      dat_we_i  = e.we;
      dat_cyc_i = 1'b1;
      dat_stb_i = 1'b1;
    end
    while (ins_busy || dat_busy) begin
      @(negedge HCLK);
      cycles++;
      if (ins_busy && (ins_ack_o || ins_err_o)) begin
        // Response code 2 for ack and 1 for err
        check_value({e.name, " ins resp"}, e.exp_ack ? 32'd2 : 32'd1,
                    32'({ins_ack_o, ins_err_o}));
        check_value({e.name, " ins latency"}, 32'(RESP_LATENCY), 32'(cycles));
        if (e.exp_ack && !e.we) begin
          check_value({e.name, " ins rdat"}, e.exp_rdat, ins_rdat_o);
        end
        ins_busy  = 1'b0;
        ins_cyc_i = 1'b0;
        ins_stb_i = 1'b0;
      end
      if (dat_busy && (dat_ack_o || dat_err_o)) begin
        check_value({e.name, " dat resp"}, e.exp_ack ? 32'd2 : 32'd1,
                    32'({dat_ack_o, dat_err_o}));
        check_value({e.name, " dat latency"}, 32'(RESP_LATENCY), 32'(cycles));
        if (e.exp_ack && !e.we) begin
          check_value({e.name, " dat rdat"}, e.exp_rdat, dat_rdat_o);
        end
        // UART pulse lines up with ack
        check_value({e.name, " uart valid"}, 32'(e.exp_uart), 32'(uart_valid_o));
        if (e.exp_uart) begin
          check_value({e.name, " uart data"}, 32'(e.exp_byte), 32'(uart_data_o));
        end
        check_value({e.name, " done"}, 32'(e.exp_done), 32'(done_o));
        check_value({e.name, " exit code"}, 32'(e.exp_exit), 32'(exit_code_o));
        dat_busy  = 1'b0;
        dat_cyc_i = 1'b0;
        dat_stb_i = 1'b0;
      end
      if ((ins_busy || dat_busy) && (cycles >= ENTRY_LIMIT)) begin
        fail_run($sformatf("no response to %s within %0d cycles", e.name, ENTRY_LIMIT));
      end
    end
  endtask

  // Watchdog sized by table length
  initial begin
    wait (table_ready);
    repeat (tbl.size() * 10 + TIMEOUT_MARGIN) @(posedge HCLK);
    fail_run("watchdog expired before the table finished");
  end

  initial begin
    HCLK        = 1'b0;
    rst_n_i     = 1'b0;
    ins_adr_i   = '0;
    ins_dat_i   = '0;
    ins_sel_i   = '0;
    ins_we_i    = 1'b0;
    ins_cyc_i   = 1'b0;
    ins_stb_i   = 1'b0;
    dat_adr_i   = '0;
    dat_dat_i   = '0;
    dat_sel_i   = '0;
    dat_we_i    = 1'b0;
    dat_cyc_i   = 1'b0;
    dat_stb_i   = 1'b0;
    lcg_state   = SEED;
    tohost_ref  = '0;
    done_ref    = 1'b0;
    exit_ref    = '0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge HCLK);
    rst_n_i = 1'b1;
    @(negedge HCLK);
    check_value("reset flags", 32'd0, 32'({ins_ack_o, ins_err_o, dat_ack_o, dat_err_o,
                                           uart_valid_o, done_o}));
    check_value("reset exit code", 32'd0, 32'(exit_code_o));
    foreach (tbl[i]) begin
      apply_entry(tbl[i]);
    end
    // Bound protocol checker must have stayed quiet
    if (wb_sys_top_inst.protocol_chk.err_cnt != 0) begin
      fail_run("a protocol assertion failed during the run");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== wb_sys_top.sv ====
`default_nettype none

module wb_sys_top (
  input  wire                       HCLK,
  input  wire                       rst_n_i,
  // Instruction port
  input  wire  [wb_pkg::PLEN-1:0]   ins_adr_i,
  input  wire  [wb_pkg::XLEN-1:0]   ins_dat_i,
  input  wire  [wb_pkg::SEL_W-1:0]  ins_sel_i,
  input  wire                       ins_we_i,
  input  wire                       ins_cyc_i,
  input  wire                       ins_stb_i,
  // Data port
  input  wire  [wb_pkg::PLEN-1:0]   dat_adr_i,
  input  wire  [wb_pkg::XLEN-1:0]   dat_dat_i,
  input  wire  [wb_pkg::SEL_W-1:0]  dat_sel_i,
  input  wire                       dat_we_i,
  input  wire                       dat_cyc_i,
  input  wire                       dat_stb_i,
  // Responses
  output logic [wb_pkg::XLEN-1:0]   ins_rdat_o,
  output logic                      ins_ack_o,
  output logic                      ins_err_o,
  output logic [wb_pkg::XLEN-1:0]   dat_rdat_o,
  output logic                      dat_ack_o,
  output logic                      dat_err_o,
  // MMIO side effects
  output logic                      uart_valid_o,
  output logic [7:0]                uart_data_o,
  output logic                      done_o,
  output logic [wb_pkg::XLEN-2:0]   exit_code_o
);

  // Instruction guard to RAM port a
  logic                     ins_main_stb;
  logic                     ins_main_ack;
  logic [wb_pkg::XLEN-1:0]  ins_main_rdat;
  logic [wb_pkg::PLEN-1:0]  ins_fwd_adr;
  logic [wb_pkg::XLEN-1:0]  ins_fwd_dat;
  logic [wb_pkg::SEL_W-1:0] ins_fwd_sel;
  logic                     ins_fwd_we;

  // Data guard to RAM port b and catcher
  logic                     dat_main_stb;
  logic                     dat_main_ack;
  logic [wb_pkg::XLEN-1:0]  dat_main_rdat;
  logic                     dat_io_stb;
  logic                     dat_io_ack;
  logic [wb_pkg::XLEN-1:0]  dat_io_rdat;
  logic [wb_pkg::PLEN-1:0]  dat_fwd_adr;
  logic [wb_pkg::XLEN-1:0]  dat_fwd_dat;
  logic [wb_pkg::SEL_W-1:0] dat_fwd_sel;
  logic                     dat_fwd_we;

  // Fetch from I/O always faults, so no I/O target here
  wb_port_guard #(.IS_FETCH(1'b1)) ins_guard (
    .HCLK        (HCLK),
    .rst_n_i     (rst_n_i),
    .adr_i       (ins_adr_i),
    .dat_i       (ins_dat_i),
    .sel_i       (ins_sel_i),
    .we_i        (ins_we_i),
    .cyc_i       (ins_cyc_i),
    .stb_i       (ins_stb_i),
    .ack_o       (ins_ack_o),
    .err_o       (ins_err_o),
    .rdat_o      (ins_rdat_o),
    .main_stb_o  (ins_main_stb),
    .io_stb_o    (),
    .fwd_adr_o   (ins_fwd_adr),
    .fwd_dat_o   (ins_fwd_dat),
    .fwd_sel_o   (ins_fwd_sel),
    .fwd_we_o    (ins_fwd_we),
    .main_ack_i  (ins_main_ack),
    .main_rdat_i (ins_main_rdat),
    .io_ack_i    (1'b0),
    .io_rdat_i   ({wb_pkg::XLEN{1'b0}})
  );

  wb_port_guard #(.IS_FETCH(1'b0)) dat_guard (
    .HCLK        (HCLK),
    .rst_n_i     (rst_n_i),
    .adr_i       (dat_adr_i),
    .dat_i       (dat_dat_i),
    .sel_i       (dat_sel_i),
    .we_i        (dat_we_i),
    .cyc_i       (dat_cyc_i),
    .stb_i       (dat_stb_i),
    .ack_o       (dat_ack_o),
    .err_o       (dat_err_o),
    .rdat_o      (dat_rdat_o),
    .main_stb_o  (dat_main_stb),
    .io_stb_o    (dat_io_stb),
    .fwd_adr_o   (dat_fwd_adr),
    .fwd_dat_o   (dat_fwd_dat),
    .fwd_sel_o   (dat_fwd_sel),
    .fwd_we_o    (dat_fwd_we),
    .main_ack_i  (dat_main_ack),
    .main_rdat_i (dat_main_rdat),
    .io_ack_i    (dat_io_ack),
    .io_rdat_i   (dat_io_rdat)
  );

  wb_mem_model mem_model (
    .HCLK     (HCLK),
    .rst_n_i  (rst_n_i),
    .a_stb_i  (ins_main_stb),
    .a_adr_i  (ins_fwd_adr),
    .a_dat_i  (ins_fwd_dat),
    .a_sel_i  (ins_fwd_sel),
    .a_we_i   (ins_fwd_we),
    .b_stb_i  (dat_main_stb),
    .b_adr_i  (dat_fwd_adr),
    .b_dat_i  (dat_fwd_dat),
    .b_sel_i  (dat_fwd_sel),
    .b_we_i   (dat_fwd_we),
    .a_ack_o  (ins_main_ack),
    .a_rdat_o (ins_main_rdat),
    .b_ack_o  (dat_main_ack),
    .b_rdat_o (dat_main_rdat)
  );

  mmio_catcher mmio (
    .HCLK         (HCLK),
    .rst_n_i      (rst_n_i),
    .stb_i        (dat_io_stb),
    .adr_i        (dat_fwd_adr),
    .dat_i        (dat_fwd_dat),
    .sel_i        (dat_fwd_sel),
    .we_i         (dat_fwd_we),
    .ack_o        (dat_io_ack),
    .rdat_o       (dat_io_rdat),
    .uart_valid_o (uart_valid_o),
    .uart_data_o  (uart_data_o),
    .done_o       (done_o),
    .exit_code_o  (exit_code_o)
  );

endmodule

`default_nettype wire
